// ==== verilog/blit_reg_pkg.sv ====
/* Blitter A1 register map
   Select codes and field types for the A1 window registers */
package blit_reg_pkg;

	// Host register select codes
	typedef enum logic [2:0] {
		REG_BASE  = 3'd0,
		REG_FLAGS = 3'd1,
		REG_PTR   = 3'd2,
		REG_INC   = 3'd3,
		REG_INCF  = 3'd4,
		REG_WIN   = 3'd5,
		REG_FRAC  = 3'd6
	} blit_reg_e;

	// One x or y half of pointer, fraction, increment or window
	typedef logic [15:0] coord_t;

	// Host data word, y in the high half and x in the low half
	typedef logic [31:0] reg_word_t;

	// Window base counted in 8-byte phrases
	typedef logic [20:0] phrase_base_t;

	// Log2 of bits per pixel
	typedef logic [2:0] pix_size_t;

	// Log2 of line width in pixels
	typedef logic [3:0] width_exp_t;

endpackage

// ==== verilog/blit_ctrl_pkg.sv ====
/* Blitter pixel sequencer types
   Run state encoding and pixel count width */
package blit_ctrl_pkg;

	// Sequencer states
	typedef enum logic [1:0] {
		SEQ_IDLE = 2'd0,
		SEQ_RUN  = 2'd1,
		SEQ_DONE = 2'd2
	} seq_state_e;

	// Pixels in one run
	typedef logic [15:0] pix_count_t;

endpackage

// ==== verilog/blit_addr_regs.sv ====
/* A1 window register file
   Host write decode, flag field extraction and registered readback */
`timescale 1ns/100ps

module blit_addr_regs
	import blit_reg_pkg::*;
(
	input  logic         sys_clk,
	input  logic         rst_n,
	input  logic         reg_wr,
	input  logic         reg_rd,
	input  blit_reg_e    reg_sel,
	input  reg_word_t    reg_wdata,
	input  logic         busy,
	input  coord_t       ptr_x,
	input  coord_t       ptr_y,
	input  coord_t       frac_x,
	input  coord_t       frac_y,
	output logic         ptr_ld,
	output reg_word_t    ptr_wdata,
	output phrase_base_t base,
	output pix_size_t    pixsize,
	output width_exp_t   width_exp,
	output coord_t       inc_x,
	output coord_t       inc_y,
	output coord_t       incf_x,
	output coord_t       incf_y,
	output coord_t       win_x,
	output coord_t       win_y,
	output reg_word_t    reg_rdata,
	output logic         rd_valid
);

	// Full words kept so base and flags read back as written
	reg_word_t base_word;
	reg_word_t flags_word;
	reg_word_t rd_mux;

	// Pointer load, blocked during a run
	assign ptr_ld    = reg_wr && (reg_sel == REG_PTR) && !busy;
	assign ptr_wdata = reg_wdata;

	// Phrase base from bits 23:3
	assign base = base_word[23:3];
	// Flag fields
	assign pixsize   = flags_word[5:3];
	assign width_exp = flags_word[12:9];

	// Window registers; REG_PTR goes to the stepper, REG_FRAC is read-only
	always_ff @(posedge sys_clk or negedge rst_n) begin
		if (!rst_n) begin
			base_word  <= '0;
			flags_word <= '0;
			inc_x      <= '0;
			inc_y      <= '0;
			incf_x     <= '0;
			incf_y     <= '0;
			win_x      <= '0;
			win_y      <= '0;
		end else if (reg_wr) begin
			case (reg_sel)
				REG_BASE:  base_word <= reg_wdata;
				REG_FLAGS: flags_word <= reg_wdata;
				REG_INC: begin
					inc_x <= reg_wdata[15:0];
					inc_y <= reg_wdata[31:16];
				end
				REG_INCF: begin
					incf_x <= reg_wdata[15:0];
					incf_y <= reg_wdata[31:16];
				end
				REG_WIN: begin
					win_x <= reg_wdata[15:0];
					win_y <= reg_wdata[31:16];
				end
				default: ;
			endcase
		end
	end

	// Readback select
	always_comb begin
		case (reg_sel)
			REG_BASE:  rd_mux = base_word;
			REG_FLAGS: rd_mux = flags_word;
			REG_PTR:   rd_mux = {ptr_y, ptr_x};
			REG_INC:   rd_mux = {inc_y, inc_x};
			REG_INCF:  rd_mux = {incf_y, incf_x};
			REG_WIN:   rd_mux = {win_y, win_x};
			REG_FRAC:  rd_mux = {frac_y, frac_x};
			default:   rd_mux = '0;
		endcase
	end

	// One cycle read latency
	always_ff @(posedge sys_clk) begin
		if (reg_rd) begin
			reg_rdata <= rd_mux;
		end
	end

	always_ff @(posedge sys_clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_valid <= 1'b0;
		end else begin
			rd_valid <= reg_rd;
		end
	end

endmodule

// ==== verilog/blit_ptr_step.sv ====
/* A1 pointer stepper
   Pointer and fraction registers with host load and fractional-carry step */
`timescale 1ns/100ps

module blit_ptr_step
	import blit_reg_pkg::*;
(
	input  logic      sys_clk,
	input  logic      rst_n,
	input  logic      ptr_ld,
	input  logic      step,
	input  reg_word_t ptr_wdata,
	input  coord_t    inc_x,
	input  coord_t    inc_y,
	input  coord_t    incf_x,
	input  coord_t    incf_y,
	output coord_t    ptr_x,
	output coord_t    ptr_y,
	output coord_t    frac_x,
	output coord_t    frac_y
);

	// Next pointer in the high half, next fraction in the low half
	reg_word_t next_x;
	reg_word_t next_y;

	// One axis step
	// Fraction wraps, its carry goes into the integer add
	function automatic reg_word_t axis_step(coord_t ptr, coord_t frac, coord_t inc,
		coord_t incf);
		logic [16:0] frac_sum;
		coord_t      ptr_sum;
		frac_sum = {1'b0, frac} + {1'b0, incf};
		ptr_sum  = ptr + inc + coord_t'(frac_sum[16]);
		return {ptr_sum, frac_sum[15:0]};
	endfunction

	assign next_x = axis_step(ptr_x, frac_x, inc_x, incf_x);
	assign next_y = axis_step(ptr_y, frac_y, inc_y, incf_y);

	always_ff @(posedge sys_clk or negedge rst_n) begin
		if (!rst_n) begin
			ptr_x  <= '0;
			ptr_y  <= '0;
			frac_x <= '0;
			frac_y <= '0;
		end else if (ptr_ld) begin
			// Host load, fraction restarts at zero
			ptr_x  <= ptr_wdata[15:0];
			ptr_y  <= ptr_wdata[31:16];
			frac_x <= '0;
			frac_y <= '0;
		end else if (step) begin
			ptr_x  <= next_x[31:16];
			frac_x <= next_x[15:0];
			ptr_y  <= next_y[31:16];
			frac_y <= next_y[15:0];
		end
	end

endmodule

// ==== verilog/blit_addr_gen.sv ====
/* A1 address generator
   Two-stage pipe from pointer to byte address, bit offset and outside flag */
`timescale 1ns/100ps

module blit_addr_gen
	import blit_reg_pkg::*;
#(
	parameter int ADDR_W = 24
) (
	input  logic              sys_clk,
	input  logic              rst_n,
	input  logic              issue,
	input  coord_t            ptr_x,
	input  coord_t            ptr_y,
	input  coord_t            win_x,
	input  coord_t            win_y,
	input  phrase_base_t      base,
	input  pix_size_t         pixsize,
	input  width_exp_t        width_exp,
	output logic              addr_valid,
	output logic [ADDR_W-1:0] address,
	output logic [2:0]        pixa,
	output logic              outside
);

	// Line offset in pixels, y shifted by up to 15 plus x
	logic [31:0]  offset;
	// Stage one
	logic         vld_q;
	logic         out_q;
	logic [31:0]  offset_q;
	pix_size_t    pix_q;
	phrase_base_t base_q;
	// Offset scaled to bits
	logic [36:0]  bit_pos;

	assign offset  = (32'(ptr_y) << width_exp) + 32'(ptr_x);
	assign bit_pos = 37'(offset_q) << pix_q;

	// Valid bits
	always_ff @(posedge sys_clk or negedge rst_n) begin
		if (!rst_n) begin
			vld_q      <= 1'b0;
			addr_valid <= 1'b0;
		end else begin
			vld_q      <= issue;
			addr_valid <= vld_q;
		end
	end

	// Window compare and offset, unsigned
	always_ff @(posedge sys_clk) begin
		out_q    <= (ptr_x >= win_x) || (ptr_y >= win_y);
		offset_q <= offset;
		pix_q    <= pixsize;
		base_q   <= base;
	end

	// Phrase base in bytes plus the byte part of the bit position
	always_ff @(posedge sys_clk) begin
		address <= ADDR_W'({base_q, 3'b000}) + ADDR_W'(bit_pos[36:3]);
		pixa    <= bit_pos[2:0];
		outside <= out_q;
	end

endmodule

// ==== verilog/blit_pixel_seq.sv ====
/* A1 pixel sequencer
   Counts pixels of a run, drives step and issue, flags busy and done */
`timescale 1ns/100ps

module blit_pixel_seq
	import blit_ctrl_pkg::*;
(
	input  logic       sys_clk,
	input  logic       rst_n,
	input  logic       start,
	input  pix_count_t pix_count,
	output logic       step,
	output logic       issue,
	output logic       busy,
	output logic       done
);

	seq_state_e state;
	// Pixels left including the current one
	pix_count_t remain;

	// One pixel per cycle in SEQ_RUN
	assign issue = (state == SEQ_RUN);
	assign step  = (state == SEQ_RUN);
	assign busy  = (state == SEQ_RUN);
	assign done  = (state == SEQ_DONE);

	always_ff @(posedge sys_clk or negedge rst_n) begin
		if (!rst_n) begin
			state  <= SEQ_IDLE;
			remain <= '0;
		end else begin
			case (state)
				SEQ_IDLE: begin
					if (start) begin
						remain <= pix_count;
						// Empty run only pulses done
						state  <= (pix_count == '0) ? SEQ_DONE : SEQ_RUN;
					end
				end
				SEQ_RUN: begin
					remain <= remain - 1'b1;
					if (remain == pix_count_t'(1)) begin
						state <= SEQ_DONE;
					end
				end
				SEQ_DONE: begin
					state <= SEQ_IDLE;
				end
				default: begin
					state <= SEQ_IDLE;
				end
			endcase
		end
	end

endmodule

// ==== verilog/blit_addr_unit.sv ====
/* Blitter A1 address unit
   Register file, pointer stepper, address pipe and pixel sequencer */
`timescale 1ns/100ps

module blit_addr_unit
	import blit_reg_pkg::*, blit_ctrl_pkg::*;
#(
	parameter int ADDR_W = 24
) (
	input  logic              sys_clk,
	input  logic              rst_n,
	input  logic              reg_wr,
	input  logic              reg_rd,
	input  logic              start,
	input  blit_reg_e         reg_sel,
	input  reg_word_t         reg_wdata,
	input  pix_count_t        pix_count,
	output reg_word_t         reg_rdata,
	output logic              rd_valid,
	output logic              addr_valid,
	output logic              outside,
	output logic              busy,
	output logic              done,
	output logic [ADDR_W-1:0] address,
	output logic [2:0]        pixa
);

	// Register file to stepper and address pipe
	logic         ptr_ld;
	reg_word_t    ptr_wdata;
	phrase_base_t base;
	pix_size_t    pixsize;
	width_exp_t   width_exp;
	coord_t       inc_x;
	coord_t       inc_y;
	coord_t       incf_x;
	coord_t       incf_y;
	coord_t       win_x;
	coord_t       win_y;
	// Live pointer and fraction
	coord_t       ptr_x;
	coord_t       ptr_y;
	coord_t       frac_x;
	coord_t       frac_y;
	// Sequencer strobes
	logic         step;
	logic         issue;

	blit_addr_regs u_regs (
		.sys_clk   (sys_clk),
		.rst_n     (rst_n),
		.reg_wr    (reg_wr),
		.reg_rd    (reg_rd),
		.reg_sel   (reg_sel),
		.reg_wdata (reg_wdata),
		.busy      (busy),
		.ptr_x     (ptr_x),
		.ptr_y     (ptr_y),
		.frac_x    (frac_x),
		.frac_y    (frac_y),
		.ptr_ld    (ptr_ld),
		.ptr_wdata (ptr_wdata),
		.base      (base),
		.pixsize   (pixsize),
		.width_exp (width_exp),
		.inc_x     (inc_x),
		.inc_y     (inc_y),
		.incf_x    (incf_x),
		.incf_y    (incf_y),
		.win_x     (win_x),
		.win_y     (win_y),
		.reg_rdata (reg_rdata),
		.rd_valid  (rd_valid)
	);

	blit_ptr_step u_ptr_step (
		.sys_clk   (sys_clk),
		.rst_n     (rst_n),
		.ptr_ld    (ptr_ld),
		.step      (step),
		.ptr_wdata (ptr_wdata),
		.inc_x     (inc_x),
		.inc_y     (inc_y),
		.incf_x    (incf_x),
		.incf_y    (incf_y),
		.ptr_x     (ptr_x),
		.ptr_y     (ptr_y),
		.frac_x    (frac_x),
		.frac_y    (frac_y)
	);

	blit_addr_gen #(
		.ADDR_W (ADDR_W)
	) u_addr_gen (
		.sys_clk    (sys_clk),
		.rst_n      (rst_n),
		.issue      (issue),
		.ptr_x      (ptr_x),
		.ptr_y      (ptr_y),
		.win_x      (win_x),
		.win_y      (win_y),
		.base       (base),
		.pixsize    (pixsize),
		.width_exp  (width_exp),
		.addr_valid (addr_valid),
		.address    (address),
		.pixa       (pixa),
		.outside    (outside)
	);

	blit_pixel_seq u_pixel_seq (
		.sys_clk   (sys_clk),
		.rst_n     (rst_n),
		.start     (start),
		.pix_count (pix_count),
		.step      (step),
		.issue     (issue),
		.busy      (busy),
		.done      (done)
	);

endmodule

// ==== tb/blit_addr_assertions.sv ====
/* A1 address unit protocol checks
   Done pulse width, start against busy and address strobe during reset */
`timescale 1ns/100ps

module blit_addr_assertions (
	input logic sys_clk,
	input logic rst_n,
	input logic start,
	input logic busy,
	input logic done,
	input logic addr_valid
);

	// Failures seen, read by the testbench at the end
	int error_count = 0;

	// Done lasts exactly one cycle
	done_single: assert property (@(posedge sys_clk) disable iff (!rst_n) done |=> !done)
		else begin
			$error("done held for more than one cycle");
			error_count++;
		end

	// Host keeps start low during a run
	start_idle: assert property (@(posedge sys_clk) disable iff (!rst_n) start |-> !busy)
		else begin
			$error("start arrived while busy");
			error_count++;
		end

	// One cycle into reset the pipe is already clear
	reset_quiet: assert property (@(posedge sys_clk) !rst_n |=> !addr_valid)
		else begin
			$error("addr_valid seen during reset");
			error_count++;
		end

endmodule

bind blit_addr_unit blit_addr_assertions u_protocol_check (
	.sys_clk    (sys_clk),
	.rst_n      (rst_n),
	.start      (start),
	.busy       (busy),
	.done       (done),
	.addr_valid (addr_valid)
);

// ==== tb/blit_addr_tb.sv ====
/* A1 address unit testbench
   Random register and run stimulus checked against a reference model */
`timescale 1ns/100ps

module blit_addr_tb
	import blit_reg_pkg::*, blit_ctrl_pkg::*;
();

	localparam int ADDR_W    = 24;
	localparam int MAX_PIX   = 16;
	localparam int RUN_COUNT = 26;
	localparam int REG_OPS   = 400;
	// Reset, two cycles per register access, run length plus pipe drain, doubled
	localparam int WATCHDOG_NS = (10 + REG_OPS * 2 + RUN_COUNT * (MAX_PIX + 4)) * 4 * 2;

	logic              sys_clk;
	logic              rst_n;
	logic              reg_wr;
	logic              reg_rd;
	logic              start;
	blit_reg_e         reg_sel;
	reg_word_t         reg_wdata;
	pix_count_t        pix_count;
	reg_word_t         reg_rdata;
	logic              rd_valid;
	logic              addr_valid;
	logic              outside;
	logic              busy;
	logic              done;
	logic [ADDR_W-1:0] address;
	logic [2:0]        pixa;

	integer seed;
	// Model copy of the registers
	reg_word_t m_base;
	reg_word_t m_flags;
	coord_t    m_ptr_x;
	coord_t    m_ptr_y;
	coord_t    m_frac_x;
	coord_t    m_frac_y;
	coord_t    m_inc_x;
	coord_t    m_inc_y;
	coord_t    m_incf_x;
	coord_t    m_incf_y;
	coord_t    m_win_x;
	coord_t    m_win_y;
	// Expected pixels in issue order
	logic [ADDR_W-1:0] exp_addr_q[$];
	logic [2:0]        exp_pixa_q[$];
	logic              exp_out_q[$];

	blit_addr_unit #(
		.ADDR_W (ADDR_W)
	) i_dut (
		.sys_clk    (sys_clk),
		.rst_n      (rst_n),
		.reg_wr     (reg_wr),
		.reg_rd     (reg_rd),
		.start      (start),
		.reg_sel    (reg_sel),
		.reg_wdata  (reg_wdata),
		.pix_count  (pix_count),
		.reg_rdata  (reg_rdata),
		.rd_valid   (rd_valid),
		.addr_valid (addr_valid),
		.outside    (outside),
		.busy       (busy),
		.done       (done),
		.address    (address),
		.pixa       (pixa)
	);

	initial begin
		sys_clk = 1'b0;
		forever begin
			#2 sys_clk = ~sys_clk;
		end
	end

	task automatic report_fail(string msg);
		$display("%s", msg);
		$display("=== FAIL ===");
		$fatal(1, "Simulation stopped");
	endtask

	// Watchdog
	initial begin
		#(WATCHDOG_NS);
		report_fail("Timeout: the run did not finish within the expected time");
	end

	// Protocol checker failures end the run at once
	initial begin
		wait (i_dut.u_protocol_check.error_count != 0);
		report_fail("Protocol assertion failed during the run");
	end

	task automatic check_word(string name, reg_word_t exp, reg_word_t act);
		if (exp !== act) begin
			$display("FAIL %s: expected %h, actual %h", name, exp, act);
			report_fail("Register readback mismatch");
		end
	endtask

	task automatic check_addr(string name, logic [ADDR_W-1:0] exp_a, logic [2:0] exp_p,
		logic exp_o, logic [ADDR_W-1:0] act_a, logic [2:0] act_p, logic act_o);
		if (exp_a !== act_a || exp_p !== act_p || exp_o !== act_o) begin
			$display("FAIL %s: expected address %h pixa %0d outside %b, actual %h %0d %b",
				name, exp_a, exp_p, exp_o, act_a, act_p, act_o);
			report_fail("Address output mismatch");
		end
	endtask

	task automatic check_flag(string name, logic exp, logic act);
		if (exp !== act) begin
			$display("FAIL %s: expected %b, actual %b", name, exp, act);
			report_fail("Status flag mismatch");
		end
	endtask

	function automatic reg_word_t rand_word();
		return reg_word_t'($random(seed));
	endfunction

	// Readback value as the register map defines it
	function automatic reg_word_t model_word(blit_reg_e sel);
		case (sel)
			REG_BASE:  return m_base;
			REG_FLAGS: return m_flags;
			REG_PTR:   return {m_ptr_y, m_ptr_x};
			REG_INC:   return {m_inc_y, m_inc_x};
			REG_INCF:  return {m_incf_y, m_incf_x};
			REG_WIN:   return {m_win_y, m_win_x};
			REG_FRAC:  return {m_frac_y, m_frac_x};
			default:   return '0;
		endcase
	endfunction

	// Host write while idle, model follows
	task automatic write_reg(blit_reg_e sel, reg_word_t data);
		@(negedge sys_clk);
		reg_wr    = 1'b1;
		reg_sel   = sel;
		reg_wdata = data;
		case (sel)
			REG_BASE:  m_base = data;
			REG_FLAGS: m_flags = data;
			REG_PTR: begin
				{m_ptr_y, m_ptr_x}   = data;
				{m_frac_y, m_frac_x} = '0;
			end
			REG_INC:   {m_inc_y, m_inc_x} = data;
			REG_INCF:  {m_incf_y, m_incf_x} = data;
			REG_WIN:   {m_win_y, m_win_x} = data;
			default: ;
		endcase
		@(negedge sys_clk);
		reg_wr = 1'b0;
	endtask

	task automatic read_reg(string name, blit_reg_e sel);
		@(negedge sys_clk);
		reg_rd  = 1'b1;
		reg_sel = sel;
		@(negedge sys_clk);
		reg_rd = 1'b0;
		check_flag({name, " rd_valid"}, 1'b1, rd_valid);
		check_word(name, model_word(sel), reg_rdata);
	endtask

	// Carry of each fraction half goes into the pointer half
	task automatic step_model();
		logic [16:0] sum_x;
		logic [16:0] sum_y;
		sum_x    = {1'b0, m_frac_x} + {1'b0, m_incf_x};
		sum_y    = {1'b0, m_frac_y} + {1'b0, m_incf_y};
		m_ptr_x  = m_ptr_x + m_inc_x + coord_t'(sum_x[16]);
		m_ptr_y  = m_ptr_y + m_inc_y + coord_t'(sum_y[16]);
		m_frac_x = sum_x[15:0];
		m_frac_y = sum_y[15:0];
	endtask

	// Address rule in wide arithmetic
	task automatic queue_pixel();
		longint unsigned offset;
		longint unsigned bit_pos;
		longint unsigned byte_addr;
		offset    = (longint'(m_ptr_y) << m_flags[12:9]) + longint'(m_ptr_x);
		bit_pos   = offset << m_flags[5:3];
		byte_addr = longint'(m_base[23:3]) * 8 + (bit_pos >> 3);
		exp_addr_q.push_back(byte_addr[ADDR_W-1:0]);
		exp_pixa_q.push_back(bit_pos[2:0]);
		exp_out_q.push_back((m_ptr_x >= m_win_x) || (m_ptr_y >= m_win_y));
	endtask

	// One run, cycle c counted from start; optional pointer writes while busy
	task automatic run_pixels(string name, int n, bit lock_writes);
		int  c;
		bit  done_seen;
		for (int i = 0; i < n; i++) begin
			queue_pixel();
			step_model();
		end
		@(negedge sys_clk);
		start     = 1'b1;
		pix_count = pix_count_t'(n);
		@(negedge sys_clk);
		start     = 1'b0;
		c         = 1;
		done_seen = 1'b0;
		while (!done_seen || exp_addr_q.size() != 0) begin
			check_flag({name, " busy"}, c <= n, busy);
			check_flag({name, " done"}, c == n + 1, done);
			check_flag({name, " addr_valid"}, c >= 3 && c <= n + 2, addr_valid);
			if (addr_valid) begin
				check_addr(name, exp_addr_q.pop_front(), exp_pixa_q.pop_front(),
					exp_out_q.pop_front(), address, pixa, outside);
			end
			done_seen = done_seen || done;
			reg_wr    = lock_writes && busy;
			reg_sel   = REG_PTR;
			reg_wdata = rand_word();
			c++;
			@(negedge sys_clk);
		end
		reg_wr = 1'b0;
	endtask

	task automatic write_flags();
		reg_word_t w;
		w      = rand_word();
		w[5:3] = 3'({$random(seed)} % 6);
		write_reg(REG_FLAGS, w);
	endtask

	initial begin
		seed      = 73446;
		rst_n     = 1'b0;
		reg_wr    = 1'b0;
		reg_rd    = 1'b0;
		start     = 1'b0;
		reg_sel   = REG_BASE;
		reg_wdata = '0;
		pix_count = '0;
		{m_base, m_flags, m_ptr_x, m_ptr_y, m_frac_x, m_frac_y} = '0;
		{m_inc_x, m_inc_y, m_incf_x, m_incf_y, m_win_x, m_win_y} = '0;
		repeat (10) @(posedge sys_clk);
		@(negedge sys_clk);
		rst_n = 1'b1;

		// Readback of every register and of the read-only fraction
		for (int i = 0; i < 10; i++) begin
			for (int s = 0; s <= 5; s++) begin
				write_reg(blit_reg_e'(s), rand_word());
				read_reg("readback", blit_reg_e'(s));
			end
			write_reg(REG_FRAC, rand_word());
			read_reg("frac read-only", REG_FRAC);
		end

		// Address rule with a still pointer
		write_reg(REG_INC, '0);
		write_reg(REG_INCF, '0);
		for (int i = 0; i < 6; i++) begin
			write_flags();
			write_reg(REG_BASE, rand_word());
			write_reg(REG_WIN, rand_word());
			write_reg(REG_PTR, rand_word());
			run_pixels("address", 1 + {$random(seed)} % 6, 1'b0);
		end

		// Fractional stepping with final pointer and fraction
		// A pointer load after the run clears the stepped fraction
		for (int i = 0; i < 6; i++) begin
			write_flags();
			write_reg(REG_PTR, rand_word());
			write_reg(REG_INC, rand_word());
			write_reg(REG_INCF, rand_word());
			run_pixels("stepping", 1 + {$random(seed)} % MAX_PIX, 1'b0);
			read_reg("stepping ptr", REG_PTR);
			read_reg("stepping frac", REG_FRAC);
			write_reg(REG_PTR, rand_word());
			read_reg("frac after ptr", REG_FRAC);
		end

		// Pointer walks across random window edges
		for (int i = 0; i < 4; i++) begin
			m_win_x = coord_t'({$random(seed)} % 256 + 4);
			m_win_y = coord_t'({$random(seed)} % 256 + 4);
			write_reg(REG_WIN, {m_win_y, m_win_x});
			write_reg(REG_PTR, {m_win_y - 16'd1, m_win_x - 16'd3});
			write_reg(REG_INC, 32'h0000_0001);
			write_reg(REG_INCF, rand_word());
			run_pixels("window", 12, 1'b0);
		end

		// Run control
		run_pixels("count zero", 0, 1'b0);
		run_pixels("count one", 1, 1'b0);
		run_pixels("count two", 2, 1'b0);
		run_pixels("count max", MAX_PIX, 1'b0);

		// Pointer writes during a run are dropped
		for (int i = 0; i < 2; i++) begin
			write_reg(REG_PTR, rand_word());
			write_reg(REG_INC, rand_word());
			write_reg(REG_INCF, rand_word());
			run_pixels("lockout", MAX_PIX, 1'b1);
			read_reg("lockout ptr", REG_PTR);
			read_reg("lockout frac", REG_FRAC);
		end

		repeat (4) @(negedge sys_clk);
		if (i_dut.u_protocol_check.error_count == 0) begin
			$display("=== PASS ===");
			$finish;
		end else begin
			report_fail("Protocol assertion failed during the run");
		end
	end

endmodule

// ==== files.f ====
verilog/blit_reg_pkg.sv
verilog/blit_ctrl_pkg.sv
verilog/blit_addr_regs.sv
verilog/blit_ptr_step.sv
verilog/blit_addr_gen.sv
verilog/blit_pixel_seq.sv
verilog/blit_addr_unit.sv
tb/blit_addr_assertions.sv
tb/blit_addr_tb.sv
